// File: common/net_pkg.sv
package net_pkg;

    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;

    // all headers are in wire order, first byte in the top bits
    typedef struct packed {
        mac_addr_t   dst_mac;
        mac_addr_t   src_mac;
        logic [15:0] ethertype;
    } eth_hdr_t;

    typedef struct packed {
        logic [3:0]  version;
        logic [3:0]  ihl;
        logic [5:0]  dscp;
        logic [1:0]  ecn;
        logic [15:0] total_length;
        logic [15:0] identification;
        // reserved, don't fragment, more fragments
        logic [2:0]  flags;
        logic [12:0] frag_offset;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [15:0] checksum;
        ip_addr_t    src_ip;
        ip_addr_t    dst_ip;
    } ipv4_hdr_t;

    typedef struct packed {
        udp_port_t   src_port;
        udp_port_t   dst_port;
        logic [15:0] length;
        logic [15:0] checksum;
    } udp_hdr_t;

    localparam logic [15:0] ethertype_ipv4 = 16'h0800;
    localparam logic [7:0]  ip_proto_udp   = 8'd17;
    localparam mac_addr_t   mac_broadcast  = '1;

endpackage

// File: common/stack_pkg.sv
package stack_pkg;

    // byte counts for lengths on the user side
    typedef logic [15:0] len_t;

    // 11:22:33:44:55:66
    localparam logic [47:0] default_local_mac = 48'h11_22_33_44_55_66;

    // 192.168.1.128
    localparam logic [31:0] default_local_ip = {8'd192, 8'd168, 8'd1, 8'd128};

    localparam logic [15:0] default_listen_port = 16'd1234;

endpackage

// File: common/byte_stream_if.sv
interface byte_stream_if;

    logic [7:0] data;
    logic       valid;
    logic       ready;
    logic       last;
    // on the last byte, flags a bad or cut-off frame
    logic       user;

    modport source (
        output data, valid, last, user,
        input  ready
    );

    modport sink (
        input  data, valid, last, user,
        output ready
    );

endinterface

// File: source/hdr_strip.sv
module hdr_strip #(
    parameter type hdr_t = logic [15:0]
) (
    input  logic           clk,
    input  logic           rst,
    byte_stream_if.sink    in,
    byte_stream_if.source  out,
    output hdr_t           hdr,
    output logic           hdr_done,
    input  logic           keep
);

    localparam int hdr_w     = $bits(hdr_t);
    localparam int hdr_bytes = hdr_w / 8;
    localparam int cnt_w     = $clog2(hdr_bytes + 1);

    logic [cnt_w-1:0] byte_cnt;
    logic             ready_en;
    logic             in_fire;

    assign in_fire = in.valid && in.ready;

    // payload passes straight through once the header is in
    assign out.data  = in.data;
    assign out.last  = in.last;
    assign out.user  = in.user;
    assign out.valid = in.valid && hdr_done && keep;

    // header bytes and rejected frames never stall
    assign in.ready = ready_en && (!hdr_done || !keep || out.ready);

    always_ff @(posedge clk) begin
        if (rst) begin
            ready_en <= 1'b0;
            hdr_done <= 1'b0;
            byte_cnt <= '0;
        end else begin
            ready_en <= 1'b1;
            if (in_fire) begin
                if (hdr_done) begin
                    if (in.last) begin
                        hdr_done <= 1'b0;
                    end
                end else if (in.last) begin
                    // frame ended inside the header, drop it
                    byte_cnt <= '0;
                end else if (byte_cnt == cnt_w'(hdr_bytes - 1)) begin
                    byte_cnt <= '0;
                    hdr_done <= 1'b1;
                end else begin
                    byte_cnt <= byte_cnt + 1'b1;
                end
            end
        end
    end

    // shift register, first wire byte ends up on top
    always_ff @(posedge clk) begin
        if (in_fire && !hdr_done) begin
            hdr <= hdr_t'({hdr[hdr_w-9:0], in.data});
        end
    end

endmodule

// File: source/eth_rx.sv
module eth_rx
    import net_pkg::*;
#(
    parameter mac_addr_t local_mac = '0
) (
    input  logic           clk,
    input  logic           rst,
    byte_stream_if.sink    in,
    byte_stream_if.source  out
);

    eth_hdr_t hdr;
    logic     hdr_done;
    logic     keep;
    logic     mac_match;
    logic     type_match;

    // unicast to us or broadcast
    assign mac_match = (hdr.dst_mac == local_mac) || (hdr.dst_mac == mac_broadcast);

    // ARP and anything else is dropped here
    assign type_match = (hdr.ethertype == ethertype_ipv4);

    assign keep = hdr_done && mac_match && type_match;

    hdr_strip #(
        .hdr_t (eth_hdr_t)
    ) strip_i (
        .clk      (clk),
        .rst      (rst),
        .in       (in),
        .out      (out),
        .hdr      (hdr),
        .hdr_done (hdr_done),
        .keep     (keep)
    );

endmodule

// File: source/ipv4_rx.sv
module ipv4_rx
    import net_pkg::*;
#(
    parameter ip_addr_t local_ip = '0
) (
    input  logic           clk,
    input  logic           rst,
    byte_stream_if.sink    in,
    byte_stream_if.source  out,
    output ip_addr_t       src_ip
);

    ipv4_hdr_t   hdr;
    logic        hdr_done;
    logic        hdr_done_q;
    logic        keep;
    logic [15:0] pay_len;
    logic [15:0] byte_cnt;
    logic        final_byte;
    logic        trim_done;

    byte_stream_if pay ();

    // no options, no fragments, UDP only
    assign keep = hdr_done
               && hdr.version == 4'd4
               && hdr.ihl == 4'd5
               && hdr.frag_offset == '0
               && !hdr.flags[0]
               && hdr.protocol == ip_proto_udp
               && hdr.dst_ip == local_ip
               && hdr.total_length >= 16'd28;

    hdr_strip #(
        .hdr_t (ipv4_hdr_t)
    ) strip_i (
        .clk      (clk),
        .rst      (rst),
        .in       (in),
        .out      (pay.source),
        .hdr      (hdr),
        .hdr_done (hdr_done),
        .keep     (keep)
    );

    assign pay_len    = hdr.total_length - 16'd20;
    assign final_byte = (byte_cnt == pay_len - 16'd1);

    // ethernet padding is swallowed once the datagram is complete
    assign out.data  = pay.data;
    assign out.valid = pay.valid && !trim_done;
    assign out.last  = pay.last || final_byte;
    assign out.user  = pay.user || (pay.last && !final_byte);
    assign pay.ready = out.ready || trim_done;

    always_ff @(posedge clk) begin
        if (rst) begin
            byte_cnt   <= '0;
            trim_done  <= 1'b0;
            hdr_done_q <= 1'b0;
        end else begin
            hdr_done_q <= hdr_done;
            if (pay.valid && pay.ready) begin
                if (pay.last) begin
                    byte_cnt  <= '0;
                    trim_done <= 1'b0;
                end else if (!trim_done) begin
                    if (final_byte) begin
                        trim_done <= 1'b1;
                    end else begin
                        byte_cnt <= byte_cnt + 16'd1;
                    end
                end
            end
        end
    end

    // sideband for the UDP layer
    always_ff @(posedge clk) begin
        if (hdr_done && !hdr_done_q) begin
            src_ip <= hdr.src_ip;
        end
    end

endmodule

// File: source/udp_rx.sv
module udp_rx
    import net_pkg::*;
    import stack_pkg::*;
#(
    parameter udp_port_t listen_port = '0
) (
    input  logic          clk,
    input  logic          rst,
    byte_stream_if.sink   in,
    input  ip_addr_t      src_ip,
    output logic          udp_hdr_valid,
    input  logic          udp_hdr_ready,
    output ip_addr_t      udp_src_ip,
    output udp_port_t     udp_src_port,
    output len_t          udp_length,
    output logic [7:0]    out_data,
    output logic          out_valid,
    input  logic          out_ready,
    output logic          out_last,
    output logic          out_user
);

    udp_hdr_t hdr;
    logic     hdr_done;
    logic     keep;
    logic     hdr_sent;

    byte_stream_if pay ();

    assign keep = hdr_done && hdr.dst_port == listen_port && hdr.length >= 16'd8;

    hdr_strip #(
        .hdr_t (udp_hdr_t)
    ) strip_i (
        .clk      (clk),
        .rst      (rst),
        .in       (in),
        .out      (pay.source),
        .hdr      (hdr),
        .hdr_done (hdr_done),
        .keep     (keep)
    );

    // header fields come from frozen registers, stable while valid
    assign udp_hdr_valid = keep && !hdr_sent;
    assign udp_src_ip    = src_ip;
    assign udp_src_port  = hdr.src_port;
    assign udp_length    = len_t'(hdr.length - 16'd8);

    // payload waits for the header handshake
    assign out_data  = pay.data;
    assign out_last  = pay.last;
    assign out_user  = pay.user;
    assign out_valid = pay.valid && hdr_sent;
    assign pay.ready = out_ready && hdr_sent;

    always_ff @(posedge clk) begin
        if (rst) begin
            hdr_sent <= 1'b0;
        end else if (udp_hdr_valid && udp_hdr_ready) begin
            hdr_sent <= 1'b1;
        end else if (pay.valid && pay.ready && pay.last) begin
            hdr_sent <= 1'b0;
        end
    end

endmodule

// File: source/udp_rx_top.sv
module udp_rx_top
    import net_pkg::*;
    import stack_pkg::*;
#(
    parameter mac_addr_t local_mac   = default_local_mac,
    parameter ip_addr_t  local_ip    = default_local_ip,
    parameter udp_port_t listen_port = default_listen_port
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [7:0]  in_data,
    input  logic        in_valid,
    output logic        in_ready,
    input  logic        in_last,
    input  logic        in_user,
    output logic        udp_hdr_valid,
    input  logic        udp_hdr_ready,
    output ip_addr_t    udp_src_ip,
    output udp_port_t   udp_src_port,
    output len_t        udp_length,
    output logic [7:0]  out_data,
    output logic        out_valid,
    input  logic        out_ready,
    output logic        out_last,
    output logic        out_user
);

    byte_stream_if mac_s ();
    byte_stream_if eth_s ();
    byte_stream_if ip_s ();
    ip_addr_t      ip_src;

    assign mac_s.data  = in_data;
    assign mac_s.valid = in_valid;
    assign mac_s.last  = in_last;
    assign mac_s.user  = in_user;
    assign in_ready    = mac_s.ready;

    eth_rx #(
        .local_mac (local_mac)
    ) eth_i (
        .clk (clk),
        .rst (rst),
        .in  (mac_s.sink),
        .out (eth_s.source)
    );

    ipv4_rx #(
        .local_ip (local_ip)
    ) ipv4_i (
        .clk    (clk),
        .rst    (rst),
        .in     (eth_s.sink),
        .out    (ip_s.source),
        .src_ip (ip_src)
    );

    udp_rx #(
        .listen_port (listen_port)
    ) udp_i (
        .clk           (clk),
        .rst           (rst),
        .in            (ip_s.sink),
        .src_ip        (ip_src),
        .udp_hdr_valid (udp_hdr_valid),
        .udp_hdr_ready (udp_hdr_ready),
        .udp_src_ip    (udp_src_ip),
        .udp_src_port  (udp_src_port),
        .udp_length    (udp_length),
        .out_data      (out_data),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_last      (out_last),
        .out_user      (out_user)
    );

endmodule

// File: sim/clk_gen.sv
module clk_gen #(
    parameter int period       = 4,
    parameter int reset_cycles = 8
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // reset drops just after a rising edge, like every other input
    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

// File: sim/udp_rx_tb.sv
module udp_rx_tb
    import net_pkg::*;
    import stack_pkg::*;
();

    localparam int n_frames       = 60;
    localparam int max_frame_len  = 90;
    localparam int timeout_cycles = 4 * n_frames * max_frame_len;

    logic        clk;
    logic        rst;
    logic [7:0]  in_data;
    logic        in_valid;
    logic        in_ready;
    logic        in_last;
    logic        in_user;
    logic        udp_hdr_valid;
    logic        udp_hdr_ready;
    ip_addr_t    udp_src_ip;
    udp_port_t   udp_src_port;
    len_t        udp_length;
    logic [7:0]  out_data;
    logic        out_valid;
    logic        out_ready;
    logic        out_last;
    logic        out_user;

    logic [15:0] lfsr_state = 16'd40659;
    // expected header is {src ip, src port, length}, expected byte is {user, last, data}
    logic [63:0] exp_hdr_q[$];
    logic [9:0]  exp_byte_q[$];
    logic [7:0]  frame[$];
    int          errors    = 0;
    int          checks    = 0;
    int          cycle_cnt = 0;
    logic        hdr_seen  = 1'b0;

    // fields of the frame being built
    eth_hdr_t    eh;
    ipv4_hdr_t   ih;
    udp_hdr_t    uh;
    int          pay_len;
    int          cut_len;
    logic        cut;

    clk_gen #(
        .period       (4),
        .reset_cycles (8)
    ) clk_gen_i (
        .clk (clk),
        .rst (rst)
    );

    udp_rx_top dut_i (.*);

    // feedback taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic tick();
        @(posedge clk);
        #1;
        out_ready     = (take_bits(2) != 0);
        udp_hdr_ready = (take_bits(1) != 0);
    endtask

    task automatic send_byte(input logic [7:0] data, input logic last, input logic user);
        logic accepted;
        while (take_bits(2) == 0)
            tick();
        in_data  = data;
        in_last  = last;
        in_user  = user;
        in_valid = 1'b1;
        // ready is stable at the falling edge, the byte moves on the next rising edge
        do begin
            @(negedge clk);
            accepted = in_ready;
            tick();
        end while (!accepted);
        in_valid = 1'b0;
    endtask

    task automatic build_frame();
        int mut;
        int pad;
        mut     = take_bits(4);
        pad     = 0;
        cut     = 1'b0;
        pay_len = take_bits(5) + 1;
        for (int i = 0; i < 14; i++)
            eh = eth_hdr_t'({eh[103:0], 8'(take_bits(8))});
        for (int i = 0; i < 20; i++)
            ih = ipv4_hdr_t'({ih[151:0], 8'(take_bits(8))});
        for (int i = 0; i < 8; i++)
            uh = udp_hdr_t'({uh[55:0], 8'(take_bits(8))});
        eh.dst_mac      = default_local_mac;
        eh.ethertype    = ethertype_ipv4;
        ih.version      = 4'd4;
        ih.ihl          = 4'd5;
        ih.total_length = 16'(28 + pay_len);
        ih.flags[2]     = 1'b0;
        ih.flags[0]     = 1'b0;
        ih.frag_offset  = '0;
        ih.protocol     = ip_proto_udp;
        ih.dst_ip       = default_local_ip;
        uh.dst_port     = default_listen_port;
        uh.length       = 16'(8 + pay_len);
        case (mut)
            0: eh.dst_mac ^= 48'(take_bits(16)) | 48'h1;
            1: eh.dst_mac = mac_broadcast;
            2: eh.ethertype = 16'h0806;
            3: ih.dst_ip ^= take_bits(32) | 32'h1;
            4: ih.protocol = 8'd6;
            5: ih.ihl = 4'd6;
            6: begin
                if (take_bits(1) != 0)
                    ih.flags[0] = 1'b1;
                else
                    ih.frag_offset = 13'd185;
            end
            7: uh.dst_port ^= 16'(take_bits(16)) | 16'h1;
            8: pad = take_bits(4) + 1;
            9: cut = 1'b1;
            default: ;
        endcase
        frame.delete();
        for (int i = 13; i >= 0; i--)
            frame.push_back(eh[i*8 +: 8]);
        for (int i = 19; i >= 0; i--)
            frame.push_back(ih[i*8 +: 8]);
        for (int i = 7; i >= 0; i--)
            frame.push_back(uh[i*8 +: 8]);
        // payload, then padding up to the 60 byte minimum plus any extra
        cut_len = (42 + pay_len < 60) ? 60 + pad : 42 + pay_len + pad;
        while (frame.size() < cut_len)
            frame.push_back(8'(take_bits(8)));
        if (cut)
            cut_len = take_bits(7) % (frame.size() - 1) + 1;
    endtask

    // acceptance rules applied to the fields, then the bytes that survive
    task automatic predict_frame();
        logic eth_ok;
        logic ip_ok;
        logic end_user;
        int   dgram_len;
        int   ip_bytes;
        int   n_pay;
        eth_ok = (eh.dst_mac == default_local_mac || eh.dst_mac == mac_broadcast)
              && eh.ethertype == 16'h0800;
        ip_ok  = ih.version == 4'd4 && ih.ihl == 4'd5 && ih.frag_offset == 0 && !ih.flags[0]
              && ih.protocol == 8'd17 && ih.dst_ip == default_local_ip
              && ih.total_length >= 16'd28;
        dgram_len = ih.total_length - 20;
        ip_bytes  = cut_len - 34;
        end_user  = (ip_bytes < dgram_len) || (cut && ip_bytes == dgram_len);
        n_pay     = ((ip_bytes < dgram_len) ? ip_bytes : dgram_len) - 8;
        if (!(eth_ok && ip_ok && uh.dst_port == default_listen_port && n_pay > 0))
            return;
        // the header reports the payload size the datagram was built with
        exp_hdr_q.push_back({ih.src_ip, uh.src_port, 16'(pay_len)});
        for (int i = 0; i < n_pay; i++)
            exp_byte_q.push_back({end_user && i == n_pay - 1, i == n_pay - 1, frame[42 + i]});
    endtask

    initial begin
        in_data       = '0;
        in_valid      = 1'b0;
        in_last       = 1'b0;
        in_user       = 1'b0;
        out_ready     = 1'b0;
        udp_hdr_ready = 1'b0;
        @(negedge rst);
        tick();
        for (int f = 0; f < n_frames; f++) begin
            build_frame();
            predict_frame();
            for (int i = 0; i < cut_len; i++)
                send_byte(frame[i], i == cut_len - 1, cut && i == cut_len - 1);
        end
        while (exp_hdr_q.size() != 0 || exp_byte_q.size() != 0)
            tick();
        // a few more cycles so stray output still gets caught
        repeat (20) tick();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

    always @(negedge clk) begin : monitor
        logic [63:0] exp_h;
        logic [9:0]  exp_b;
        if (!rst && udp_hdr_valid && udp_hdr_ready) begin
            checks++;
            assert (exp_hdr_q.size() != 0 && !hdr_seen) else begin
                errors++;
                $display("unexpected header handshake at time %0t", $time);
            end
            if (exp_hdr_q.size() != 0) begin
                exp_h = exp_hdr_q.pop_front();
                assert ({udp_src_ip, udp_src_port, udp_length} == exp_h) else begin
                    errors++;
                    $display("[FAIL] %0t: header got %h %h %0d, expected %h %h %0d", $time,
                             udp_src_ip, udp_src_port, udp_length,
                             exp_h[63:32], exp_h[31:16], exp_h[15:0]);
                end
            end
            hdr_seen = 1'b1;
        end
        if (!rst && out_valid && out_ready) begin
            checks++;
            assert (exp_byte_q.size() != 0 && hdr_seen) else begin
                errors++;
                $display("payload byte not expected or without a header at time %0t", $time);
            end
            if (exp_byte_q.size() != 0) begin
                exp_b = exp_byte_q.pop_front();
                assert ({out_user, out_last, out_data} == exp_b) else begin
                    errors++;
                    $display("[FAIL] %0t: byte got %h last %b user %b, expected %h last %b user %b",
                             $time, out_data, out_last, out_user,
                             exp_b[7:0], exp_b[8], exp_b[9]);
                end
            end
            if (out_last)
                hdr_seen = 1'b0;
        end
    end

    always @(posedge clk)
        cycle_cnt <= cycle_cnt + 1;

    initial begin
        wait (cycle_cnt >= timeout_cycles);
        $display("timeout after %0d cycles, %0d headers and %0d bytes never arrived",
                 cycle_cnt, exp_hdr_q.size(), exp_byte_q.size());
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: filelist.f
common/net_pkg.sv
common/stack_pkg.sv
common/byte_stream_if.sv
source/hdr_strip.sv
source/eth_rx.sv
source/ipv4_rx.sv
source/udp_rx.sv
source/udp_rx_top.sv
sim/clk_gen.sv
sim/udp_rx_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module udp_rx_tb \
    -f filelist.f -o udp_rx_sim \
    && ./obj_dir/udp_rx_sim 2>&1 | tee sim.log \
    || { echo "build or simulation run did not complete"; exit 1; }
grep -q "TESTBENCH FAILED" sim.log && { echo "failure reported in sim.log"; exit 1; }
exit 0
